// File: common/video_mixer_pkg.sv
package video_mixer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // pixel and colour types
    ////////////////////////////////////////////////////////////////////////////

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

    // one layer pixel, active marks a drawn pixel
    typedef struct packed {
        logic   active;
        rgb12_t color;
    } layer_pix_t;

    // position, sync and qualifiers for the current pixel
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       in_display;
        logic       v_sync_n;
        logic       h_sync_n;
        // foreground shown only when enabled and not masked
        logic       fg_enable;
        logic       fg_mask;
        rgb12_t     bg;
    } pixel_in_t;

    // collision report, kind is one-hot
    typedef struct packed {
        logic       valid;
        logic [2:0] kind;
        logic [8:0] x;
        logic [7:0] y;
    } coll_event_t;

    ////////////////////////////////////////////////////////////////////////////
    // collision kinds, land in bits 7..5 of the x high register
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [2:0] coll_kind_fg   = 3'b100;
    localparam logic [2:0] coll_kind_spr1 = 3'b010;
    localparam logic [2:0] coll_kind_spr2 = 3'b001;

    // cpu register map
    localparam logic [7:0] reg_screen_ctrl = 8'h20;
    localparam logic [7:0] reg_coll_y      = 8'h21;
    localparam logic [7:0] reg_coll_x_lo   = 8'h22;
    localparam logic [7:0] reg_coll_x_hi   = 8'h23;

    // screen control after reset, enabled, scanlines off
    localparam logic [7:0] screen_ctrl_reset = 8'h82;
    localparam int         screen_enable_bit = 7;
    localparam int         scanline_bit      = 0;
    // dimmed channel is divided by four
    localparam int         scanline_shift    = 2;

endpackage

// File: hw/cpu_port/cpu_port_fsm.sv
module cpu_port_fsm
    import video_mixer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       io_rd_n,
    input  logic       io_wr_n,
    input  logic [7:0] io_addr,
    input  logic [7:0] io_wdata,
    output logic       wr_stb,
    output logic       rd_stb,
    output logic       rd_active,
    output logic [7:0] reg_addr,
    output logic [7:0] reg_wdata
);

    typedef enum logic {
        st_idle,
        st_acked
    } state_t;

    state_t state;

    // a new request is only taken while idle
    logic take_req;

    assign take_req = (state == st_idle) && (!io_wr_n || !io_rd_n);

    ////////////////////////////////////////////////////////////////////////////
    // handshake state, one strobe per request
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            wr_stb    <= 1'b0;
            rd_stb    <= 1'b0;
            rd_active <= 1'b0;
        end
        else
        begin
            // strobes last one cycle
            wr_stb <= 1'b0;
            rd_stb <= 1'b0;
            case (state)
                st_idle:
                begin
                    // write wins over a read in the same cycle
                    if (!io_wr_n)
                    begin
                        wr_stb <= 1'b1;
                        state  <= st_acked;
                    end
                    else if (!io_rd_n)
                    begin
                        rd_stb    <= 1'b1;
                        rd_active <= 1'b1;
                        state     <= st_acked;
                    end
                end
                st_acked:
                begin
                    // read data held only while the read stays low
                    rd_active <= rd_active && !io_rd_n;
                    // re-arm once both lines are back high
                    if (io_rd_n && io_wr_n)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address and data captured with the strobe
    always_ff @(posedge clk)
    begin
        if (take_req)
        begin
            reg_addr  <= io_addr;
            reg_wdata <= io_wdata;
        end
    end

endmodule

// File: hw/cpu_port/mixer_regs.sv
module mixer_regs
    import video_mixer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_stb,
    input  logic        rd_stb,
    input  logic        rd_active,
    input  logic [7:0]  reg_addr,
    input  logic [7:0]  reg_wdata,
    input  coll_event_t coll,
    input  logic        v_sync_n,
    output logic [7:0]  screen_ctrl,
    output logic [7:0]  io_rdata,
    output logic        spr_int_n
);

    // collision capture registers
    logic [7:0] coll_y;
    logic [7:0] coll_x_lo;
    logic [7:0] coll_x_hi;

    // read path
    logic [7:0] rd_value;
    logic [7:0] rd_latch;

    // write decode
    logic ctrl_wr;
    logic coll_clr;
    // first collision since the flag was re-armed
    logic capture;
    // flag re-arm, by cpu or in vblank
    logic rearm;

    assign ctrl_wr  = wr_stb && (reg_addr == reg_screen_ctrl);
    assign coll_clr = wr_stb && (reg_addr == reg_coll_y);
    assign rearm    = coll_clr || !v_sync_n;
    assign capture  = spr_int_n && coll.valid;

    ////////////////////////////////////////////////////////////////////////////
    // screen control and collision capture
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            screen_ctrl <= screen_ctrl_reset;
            coll_y      <= 8'h00;
            coll_x_lo   <= 8'h00;
            coll_x_hi   <= 8'h00;
            spr_int_n   <= 1'b1;
        end
        else
        begin
            if (ctrl_wr)
                screen_ctrl <= reg_wdata;

            if (rearm)
            begin
                spr_int_n <= 1'b1;
                // cpu clear drops the kind bits, x bit 8 kept
                if (coll_clr)
                    coll_x_hi <= coll_x_hi & 8'h01;
            end
            else if (capture)
            begin
                // flag low holds these until re-armed
                spr_int_n <= 1'b0;
                coll_y    <= coll.y;
                coll_x_lo <= coll.x[7:0];
                coll_x_hi <= {coll.kind, 4'b0000, coll.x[8]};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read back
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (reg_addr)
            reg_screen_ctrl: rd_value = screen_ctrl;
            reg_coll_y:      rd_value = coll_y;
            reg_coll_x_lo:   rd_value = coll_x_lo;
            reg_coll_x_hi:   rd_value = coll_x_hi;
            // unmapped reads give zero
            default:         rd_value = 8'h00;
        endcase
    end

    // value frozen at the strobe
    always_ff @(posedge clk)
    begin
        if (rd_stb)
            rd_latch <= rd_value;
    end

    // driven while the read is held, zero otherwise
    // strobe cycle skipped, latch not loaded yet
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            io_rdata <= 8'h00;
        else if (rd_active && !rd_stb)
            io_rdata <= rd_latch;
        else
            io_rdata <= 8'h00;
    end

endmodule

// File: hw/pixel/layer_priority.sv
module layer_priority
    import video_mixer_pkg::*;
(
    input  pixel_in_t   pix,
    input  layer_pix_t  fg,
    input  layer_pix_t  spr1,
    input  layer_pix_t  spr2,
    output rgb12_t      chosen,
    output coll_event_t coll
);

    // foreground drawn only when enabled and not masked
    logic fg_visible;
    // sprite 2 only matters when nothing above it
    logic spr2_hit;
    logic any_hit;

    assign fg_visible = pix.fg_enable && !pix.fg_mask;
    assign spr2_hit   = spr2.active && !spr1.active && !fg_visible;
    assign any_hit    = spr1.active || spr2_hit;

    ////////////////////////////////////////////////////////////////////////////
    // colour selection by fixed layer order
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        if (fg_visible)
        begin
            // sprite 1 over the tilemap, sprite 2 hidden
            if (spr1.active)
                chosen = spr1.color;
            else
                chosen = fg.color;
        end
        else
        begin
            if (spr1.active)
                chosen = spr1.color;
            else if (spr2.active)
                chosen = spr2.color;
            else
                chosen = pix.bg;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // collision events
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        coll.valid = pix.in_display && any_hit;
        coll.x     = pix.x[8:0];
        coll.y     = pix.y[7:0];

        // kind stays zero outside the display area
        if (!coll.valid)
            coll.kind = 3'b000;
        else if (spr1.active && fg_visible)
            coll.kind = coll_kind_fg;
        else if (spr1.active)
            coll.kind = coll_kind_spr1;
        else
            coll.kind = coll_kind_spr2;
    end

endmodule

// File: hw/pixel/pixel_output.sv
module pixel_output
    import video_mixer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  rgb12_t     chosen,
    input  pixel_in_t  pix,
    input  logic [7:0] screen_ctrl,
    output rgb12_t     rgb,
    output logic       v_sync_n,
    output logic       h_sync_n
);

    // dim on even lines when scanline mode is on
    logic   dim_line;
    // screen on and inside the visible area
    logic   show;
    rgb12_t shaded;

    assign dim_line = screen_ctrl[scanline_bit] && !pix.y[0];
    assign show     = screen_ctrl[screen_enable_bit] && pix.in_display;

    always_comb
    begin
        shaded = chosen;
        if (dim_line)
        begin
            shaded.r = chosen.r >> scanline_shift;
            shaded.g = chosen.g >> scanline_shift;
            shaded.b = chosen.b >> scanline_shift;
        end
        // blanking forces black
        if (!show)
            shaded = '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // colour and syncs leave on the same edge
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rgb      <= '0;
            v_sync_n <= 1'b1;
            h_sync_n <= 1'b1;
        end
        else
        begin
            rgb      <= shaded;
            v_sync_n <= pix.v_sync_n;
            h_sync_n <= pix.h_sync_n;
        end
    end

endmodule

// File: hw/video_mixer_top.sv
module video_mixer_top
    import video_mixer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // pixel sources
    input  pixel_in_t  pix,
    input  layer_pix_t fg,
    input  layer_pix_t spr1,
    input  layer_pix_t spr2,
    // cpu i/o port, active-low requests
    input  logic       io_rd_n,
    input  logic       io_wr_n,
    input  logic [7:0] io_addr,
    input  logic [7:0] io_wdata,
    // video out
    output rgb12_t     rgb,
    output logic       v_sync_n,
    output logic       h_sync_n,
    output logic [7:0] io_rdata,
    // sprite collision, low until cleared
    output logic       spr_int_n
);

    // strobes from the port fsm
    logic        wr_stb;
    logic        rd_stb;
    logic        rd_active;
    logic [7:0]  reg_addr;
    logic [7:0]  reg_wdata;

    logic [7:0]  screen_ctrl;
    rgb12_t      chosen;
    coll_event_t coll;

    ////////////////////////////////////////////////////////////////////////////
    // cpu side
    ////////////////////////////////////////////////////////////////////////////
    cpu_port_fsm cpu_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .io_rd_n   (io_rd_n),
        .io_wr_n   (io_wr_n),
        .io_addr   (io_addr),
        .io_wdata  (io_wdata),
        .wr_stb    (wr_stb),
        .rd_stb    (rd_stb),
        .rd_active (rd_active),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata)
    );

    // vblank comes from the incoming sync
    mixer_regs regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_stb      (wr_stb),
        .rd_stb      (rd_stb),
        .rd_active   (rd_active),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .coll        (coll),
        .v_sync_n    (pix.v_sync_n),
        .screen_ctrl (screen_ctrl),
        .io_rdata    (io_rdata),
        .spr_int_n   (spr_int_n)
    );

    ////////////////////////////////////////////////////////////////////////////
    // pixel side
    ////////////////////////////////////////////////////////////////////////////
    layer_priority priority_i (
        .pix    (pix),
        .fg     (fg),
        .spr1   (spr1),
        .spr2   (spr2),
        .chosen (chosen),
        .coll   (coll)
    );

    pixel_output output_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .chosen      (chosen),
        .pix         (pix),
        .screen_ctrl (screen_ctrl),
        .rgb         (rgb),
        .v_sync_n    (v_sync_n),
        .h_sync_n    (h_sync_n)
    );

endmodule

// File: testbench/mixer_asserts.sv
module mixer_asserts
    import video_mixer_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   wr_stb,
    input logic   rd_stb,
    input logic   io_rd_n,
    input logic   io_wr_n,
    input logic   in_display,
    input rgb12_t rgb
);
    timeunit 1ns;
    timeprecision 1ps;

    logic stb;
    // set once a request was acknowledged, cleared when both lines go high
    logic busy;

    assign stb = wr_stb || rd_stb;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (io_rd_n && io_wr_n)
            busy <= 1'b0;
        else if (stb)
            busy <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // handshake and blanking properties
    ////////////////////////////////////////////////////////////////////////////
    strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        stb |=> !stb)
        else $error("strobe longer than one cycle");

    no_second_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        stb |-> !busy)
        else $error("second strobe before both requests were high");

    blank_outside: assert property (@(posedge clk) disable iff (!rst_n)
        !in_display |=> (rgb == 12'h000))
        else $error("rgb not black outside the display area");

endmodule

bind video_mixer_top mixer_asserts asserts_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_stb     (wr_stb),
    .rd_stb     (rd_stb),
    .io_rd_n    (io_rd_n),
    .io_wr_n    (io_wr_n),
    .in_display (pix.in_display),
    .rgb        (rgb)
);

// File: testbench/mixer_checker.sv
module mixer_checker
    import video_mixer_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input pixel_in_t  pix,
    input rgb12_t     rgb,
    input logic       v_sync_n,
    input logic       h_sync_n,
    input logic       spr_int_n,
    input logic [7:0] io_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;
    int check_count = 0;

    // syncs seen at the last edge and due on the outputs now
    logic exp_v;
    logic exp_h;
    logic armed = 1'b0;

    // colour by layer order then scanline dim then blanking
    function automatic rgb12_t expected_colour(pixel_in_t p, layer_pix_t f,
                                               layer_pix_t a, layer_pix_t b,
                                               logic [7:0] ctrl);
        logic   fg_on;
        rgb12_t c;
        fg_on = p.fg_enable && !p.fg_mask;
        if (a.active)
            c = a.color;
        else if (fg_on)
            c = f.color;
        else if (b.active)
            c = b.color;
        else
            c = p.bg;
        // even lines at quarter brightness
        if (ctrl[0] && !p.y[0])
            c = '{r: c.r / 4'd4, g: c.g / 4'd4, b: c.b / 4'd4};
        if (!ctrl[7] || !p.in_display)
            c = 12'h000;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_rgb(input rgb12_t exp);
        check_value("rgb", rgb, exp);
    endtask

    task automatic check_mixed(input pixel_in_t p, input layer_pix_t f,
                               input layer_pix_t a, input layer_pix_t b,
                               input logic [7:0] ctrl);
        check_rgb(expected_colour(p, f, a, b, ctrl));
    endtask

    task automatic check_rdata(input logic [7:0] exp);
        check_value("io_rdata", {4'h0, io_rdata}, {4'h0, exp});
    endtask

    // collision flag level after a capture
    task automatic check_int(input logic exp);
        check_value("spr_int_n", {11'h0, spr_int_n}, {11'h0, exp});
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    task automatic report_counts();
        $display("checks: %0d, errors: %0d", check_count, error_count);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // syncs follow the input by one cycle
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        exp_v <= pix.v_sync_n;
        exp_h <= pix.h_sync_n;
        armed <= rst_n;
    end

    always @(negedge clk)
    begin
        if (armed && rst_n)
        begin
            if (v_sync_n !== exp_v)
                check_value("v_sync_n", {11'h0, v_sync_n}, {11'h0, exp_v});
            if (h_sync_n !== exp_h)
                check_value("h_sync_n", {11'h0, h_sync_n}, {11'h0, exp_h});
        end
    end

endmodule

// File: testbench/tb_video_mixer.sv
module tb_video_mixer
    import video_mixer_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // one table row with the colours fixed per layer
    typedef struct packed {
        logic [7:0] ctrl;
        logic       fg_en;
        logic       fg_mask;
        logic       in_disp;
        logic [9:0] y;
        logic       s1;
        logic       s2;
        rgb12_t     exp;
    } row_t;

    localparam int n_rows = 15;
    localparam rgb12_t bg_c = 12'h123;
    localparam rgb12_t fg_c = 12'h456;
    localparam rgb12_t s1_c = 12'h9ab;
    localparam rgb12_t s2_c = 12'hcde;

    logic       clk = 1'b0;
    logic       rst_n;
    pixel_in_t  pix;
    layer_pix_t fg;
    layer_pix_t spr1;
    layer_pix_t spr2;
    logic       io_rd_n;
    logic       io_wr_n;
    logic [7:0] io_addr;
    logic [7:0] io_wdata;
    rgb12_t     rgb;
    logic       v_sync_n;
    logic       h_sync_n;
    logic [7:0] io_rdata;
    logic       spr_int_n;

    row_t       rows [0:n_rows-1];
    logic [7:0] cur_ctrl;

    always #50 clk = ~clk;

    video_mixer_top dut_i (.*);

    mixer_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix       (pix),
        .rgb       (rgb),
        .v_sync_n  (v_sync_n),
        .h_sync_n  (h_sync_n),
        .spr_int_n (spr_int_n),
        .io_rdata  (io_rdata)
    );

    task automatic set_pixel(input logic [9:0] x, input logic [9:0] y, input logic in_disp,
                             input logic fg_en, input logic fg_mask,
                             input logic s1, input logic s2);
        pix.x          = x;
        pix.y          = y;
        pix.in_display = in_disp;
        pix.v_sync_n   = 1'b1;
        pix.h_sync_n   = ~x[2];
        pix.fg_enable  = fg_en;
        pix.fg_mask    = fg_mask;
        pix.bg         = bg_c;
        fg             = '{active: 1'b0, color: fg_c};
        spr1           = '{active: s1, color: s1_c};
        spr2           = '{active: s2, color: s2_c};
    endtask

    // nothing drawn and no collisions
    task automatic park_pixel();
        set_pixel(10'd0, 10'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        io_wr_n  = 1'b0;
        io_addr  = addr;
        io_wdata = data;
        repeat (4) @(negedge clk);
        io_wr_n = 1'b1;
        @(negedge clk);
    endtask

    // data valid after the third edge of the request
    task automatic bus_read(input logic [7:0] addr, input logic [7:0] exp);
        io_rd_n = 1'b0;
        io_addr = addr;
        repeat (3) @(negedge clk);
        chk_i.check_rdata(exp);
        @(negedge clk);
        io_rd_n = 1'b1;
        @(negedge clk);
    endtask

    task automatic wait_int(input logic level, input string what);
        int n;
        n = 0;
        while (spr_int_n !== level && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (spr_int_n !== level)
            chk_i.note_failure(what);
    endtask

    task automatic one_pixel(input logic [9:0] x, input logic [9:0] y, input logic fg_en,
                             input logic s1, input logic s2);
        set_pixel(x, y, 1'b1, fg_en, 1'b0, s1, s2);
        @(negedge clk);
        park_pixel();
    endtask

    initial
    begin
        //////////////////////////////////////////////////////////////////////////
        // priority, scanline and blanking rows with expected values by hand
        //////////////////////////////////////////////////////////////////////////
        rows[0]  = '{8'h82, 1'b1, 1'b0, 1'b1, 10'd1, 1'b0, 1'b0, fg_c};
        rows[1]  = '{8'h82, 1'b1, 1'b0, 1'b1, 10'd1, 1'b0, 1'b1, fg_c};
        rows[2]  = '{8'h82, 1'b1, 1'b0, 1'b1, 10'd1, 1'b1, 1'b0, s1_c};
        rows[3]  = '{8'h82, 1'b1, 1'b0, 1'b1, 10'd1, 1'b1, 1'b1, s1_c};
        rows[4]  = '{8'h82, 1'b0, 1'b0, 1'b1, 10'd1, 1'b0, 1'b0, bg_c};
        rows[5]  = '{8'h82, 1'b0, 1'b0, 1'b1, 10'd1, 1'b0, 1'b1, s2_c};
        rows[6]  = '{8'h82, 1'b0, 1'b0, 1'b1, 10'd1, 1'b1, 1'b0, s1_c};
        rows[7]  = '{8'h82, 1'b0, 1'b0, 1'b1, 10'd1, 1'b1, 1'b1, s1_c};
        rows[8]  = '{8'h82, 1'b1, 1'b1, 1'b1, 10'd1, 1'b0, 1'b1, s2_c};
        // scanlines on and even lines dimmed
        rows[9]  = '{8'h83, 1'b0, 1'b0, 1'b1, 10'd2, 1'b1, 1'b0, 12'h222};
        rows[10] = '{8'h83, 1'b0, 1'b0, 1'b1, 10'd3, 1'b1, 1'b0, s1_c};
        rows[11] = '{8'h83, 1'b1, 1'b0, 1'b1, 10'd2, 1'b0, 1'b0, 12'h111};
        rows[12] = '{8'h83, 1'b0, 1'b0, 1'b1, 10'd4, 1'b0, 1'b1, 12'h333};
        // screen off and then outside the display
        rows[13] = '{8'h02, 1'b0, 1'b0, 1'b1, 10'd1, 1'b1, 1'b0, 12'h000};
        rows[14] = '{8'h82, 1'b1, 1'b0, 1'b0, 10'd1, 1'b1, 1'b1, 12'h000};

        void'($urandom(32'hdd47));
        rst_n    = 1'b0;
        io_rd_n  = 1'b1;
        io_wr_n  = 1'b1;
        io_addr  = 8'h00;
        io_wdata = 8'h00;
        park_pixel();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // a long hold writes once with the first data
        bus_read(reg_screen_ctrl, screen_ctrl_reset);
        bus_write(reg_screen_ctrl, 8'h5a);
        bus_read(reg_screen_ctrl, 8'h5a);
        io_wr_n  = 1'b0;
        io_addr  = reg_screen_ctrl;
        io_wdata = 8'hc3;
        repeat (3) @(negedge clk);
        io_wdata = 8'h11;
        repeat (7) @(negedge clk);
        io_wr_n = 1'b1;
        @(negedge clk);
        bus_read(reg_screen_ctrl, 8'hc3);
        bus_write(reg_screen_ctrl, 8'h82);
        cur_ctrl = 8'h82;

        for (int i = 0; i < n_rows; i++)
        begin
            if (rows[i].ctrl != cur_ctrl)
            begin
                park_pixel();
                bus_write(reg_screen_ctrl, rows[i].ctrl);
                cur_ctrl = rows[i].ctrl;
            end
            set_pixel(10'd5, rows[i].y, rows[i].in_disp, rows[i].fg_en, rows[i].fg_mask,
                      rows[i].s1, rows[i].s2);
            @(negedge clk);
            chk_i.check_rgb(rows[i].exp);
        end

        // random batch in normal then scanline mode
        for (int m = 0; m < 2; m++)
        begin
            park_pixel();
            cur_ctrl = (m == 0) ? 8'h82 : 8'h83;
            bus_write(reg_screen_ctrl, cur_ctrl);
            for (int i = 0; i < 12; i++)
            begin
                logic [31:0] r0;
                logic [31:0] r1;
                r0 = $urandom;
                r1 = $urandom;
                set_pixel(r1[9:0], {6'd0, r1[13:10]}, r1[14], r1[15], r1[16],
                          r0[24], r0[25]);
                pix.bg     = r0[11:0];
                fg.color   = r0[23:12];
                spr1.color = r1[28:17];
                spr2.color = {r0[31:26], r1[31:29], r1[2:0]};
                @(negedge clk);
                chk_i.check_mixed(pix, fg, spr1, spr2, cur_ctrl);
            end
        end

        //////////////////////////////////////////////////////////////////////////
        // collision capture and clearing
        //////////////////////////////////////////////////////////////////////////
        park_pixel();
        bus_write(reg_coll_y, 8'h00);
        wait_int(1'b1, "spr_int_n stayed low after a write to 0x21");
        // flag falls on the edge that registers the colliding pixel
        one_pixel(10'h1a5, 10'h037, 1'b0, 1'b1, 1'b0);
        chk_i.check_int(1'b0);
        bus_read(reg_coll_y, 8'h37);
        bus_read(reg_coll_x_lo, 8'ha5);
        bus_read(reg_coll_x_hi, 8'h41);
        // second collision must not change the capture
        one_pixel(10'h010, 10'h005, 1'b0, 1'b0, 1'b1);
        bus_read(reg_coll_y, 8'h37);
        bus_read(reg_coll_x_hi, 8'h41);
        bus_write(reg_coll_y, 8'h00);
        wait_int(1'b1, "spr_int_n stayed low after a write to 0x21");
        bus_read(reg_coll_x_hi, 8'h01);
        bus_read(reg_coll_y, 8'h37);
        // foreground hit and then vsync re-arms
        one_pixel(10'h002, 10'h003, 1'b1, 1'b1, 1'b0);
        chk_i.check_int(1'b0);
        bus_read(reg_coll_x_hi, 8'h80);
        pix.v_sync_n = 1'b0;
        @(negedge clk);
        pix.v_sync_n = 1'b1;
        wait_int(1'b1, "spr_int_n stayed low after vertical sync");

        chk_i.report_counts();
        if (chk_i.error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: compile.f
common/video_mixer_pkg.sv
hw/cpu_port/cpu_port_fsm.sv
hw/cpu_port/mixer_regs.sv
hw/pixel/layer_priority.sv
hw/pixel/pixel_output.sv
hw/video_mixer_top.sv
testbench/mixer_asserts.sv
testbench/mixer_checker.sv
testbench/tb_video_mixer.sv

// File: Makefile
# Verilator build and run for the video mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_video_mixer
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Simulation passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR JOBS VFLAGS PASS_MSG"

$(SIM_BIN): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
